// File: sim.f
source/rv_pkg.sv
source/core_sequencer.sv
source/fetch_wait_counter.sv
source/inst_decoder.sv
source/exec_unit.sv
source/reg_file.sv
source/rv_core.sv
testbench/tb_clock.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core.sv

// File: Makefile
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_rv_core.sv
/* testbench of the RV32I core: random program in a latency-2 instruction memory,
   every retirement compared against a reference model of the ISA */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int    PROG_LEN = 64;           // program words
    localparam int    NUM_TAIL = 4;            // nops retired past the program end
    localparam int    MAX_RET  = 16 * PROG_LEN; // bound on the expected trace
    localparam xlen_t NOP      = 32'h0000_0013;

    logic clk, reset, imem_req, retire, retire_we;
    xlen_t imem_addr, imem_rdata, retire_pc, retire_next_pc, retire_wdata, req_addr;
    reg_idx_t retire_rd;
    xlen_t prog [PROG_LEN];
    xlen_t model_regs [32];
    xlen_t exp_pc[$], exp_npc[$], exp_wdata[$];
    reg_idx_t exp_rd[$];
    logic exp_we[$];
    int seed, lat_cnt, ret_count;
    logic exp_ready, seen_req;

    tb_clock u_clk (.clk(clk));

    rv_core UUT (.clk(clk), .reset(reset), .imem_req(imem_req), .imem_addr(imem_addr),
                 .imem_rdata(imem_rdata), .retire(retire), .retire_pc(retire_pc),
                 .retire_next_pc(retire_next_pc), .retire_we(retire_we),
                 .retire_rd(retire_rd), .retire_wdata(retire_wdata));

    function automatic xlen_t rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic in_prog(xlen_t addr);
        in_prog = (addr - RESET_PC) < xlen_t'(PROG_LEN * 4);
    endfunction

    function automatic xlen_t fetch_word(xlen_t addr);
        fetch_word = (in_prog(addr) && addr[1:0] == 2'b00) ? prog[(addr - RESET_PC) >> 2] : NOP;
    endfunction

    function automatic xlen_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, xlen_t off);
        enc_b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic xlen_t enc_j(reg_idx_t rd, xlen_t off);
        enc_j = {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    function automatic xlen_t alu_ref(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
        case (f3)
            3'd0:    alu_ref = alt ? a - b : a + b;
            3'd1:    alu_ref = a << b[4:0];
            3'd2:    alu_ref = {31'b0, $signed(a) < $signed(b)};
            3'd3:    alu_ref = {31'b0, a < b};
            3'd4:    alu_ref = a ^ b;
            3'd5:    alu_ref = alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    // one instruction on the model state, register write left to the caller
    function automatic void ref_step(input xlen_t pc, input xlen_t inst, output logic we,
                                     output reg_idx_t rd, output xlen_t wd, output xlen_t npc);
        xlen_t a, b, imm_i, imm_b, imm_j;
        logic [2:0] f3;
        logic wr, taken;
        a = model_regs[inst[19:15]];
        b = model_regs[inst[24:20]];
        f3 = inst[14:12];
        rd = inst[11:7];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        wr = 1'b1;
        wd = '0;
        npc = pc + 32'd4;
        case (inst[6:0])
            OP:     wd = alu_ref(f3, inst[30], a, b);
            OP_IMM: wd = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);
            LUI:    wd = {inst[31:12], 12'b0};
            AUIPC:  wd = pc + {inst[31:12], 12'b0};
            JAL: begin
                wd = pc + 32'd4;
                npc = pc + imm_j;
            end
            JALR: begin
                wd = pc + 32'd4;
                npc = (a + imm_i) & ~32'h1;
            end
            BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    taken = a == b;
                    3'd1:    taken = a != b;
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) npc = pc + imm_b;
            end
            default: wr = 1'b0;
        endcase
        we = wr && rd != 5'd0;
    endfunction

    task automatic gen_program();
        xlen_t r, r2, base, off, upper;
        int i, kind, span, k;
        logic [2:0] f3;
        reg_idx_t rd, rs1, rs2;
        for (i = 0; i < PROG_LEN; i++) begin
            r = rand_word();
            r2 = rand_word();
            kind = int'(r[3:0]);
            rd = r[8:4];
            rs1 = r[13:9];
            rs2 = r[18:14];
            f3 = r[21:19];
            span = PROG_LEN - 1 - i;
            if (kind <= 4) begin
                prog[i] = {1'b0, r[22] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, OP};
            end else if (kind == 9 || kind == 10) begin
                prog[i] = {r2[31:12], rd, (kind == 9) ? LUI : AUIPC};
            end else if ((kind == 11 || kind == 12) && span >= 2) begin
                k = 2 + int'(r2[3:0]) % (span - 1);
                if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd4; // only real branch codes
                prog[i] = enc_b(f3, rs1, rs2, xlen_t'(k * 4));
            end else if (kind == 13 && span >= 2) begin
                k = 2 + int'(r2[3:0]) % (span - 1);
                prog[i] = enc_j(rd, xlen_t'(k * 4));
            end else if (kind >= 14 && span >= 3) begin
                k = i + 3 + int'(r2[2:0]) % (span - 2); // jalr target word
                off = {31'b0, r2[8]};                   // odd offset tests bit 0 clearing
                base = RESET_PC + xlen_t'(k * 4);
                upper = (base + 32'h800) >> 12;
                rs1 = rs1 | 5'd1;
                prog[i] = {upper[19:0], rs1, LUI};
                prog[i + 1] = {base[11:0], rs1, 3'd0, rs1, OP_IMM};
                prog[i + 2] = {off[11:0], rs1, 3'd0, rd, JALR};
                i = i + 2;
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                prog[i] = {1'b0, r[22] && f3 == 3'd5, 5'b0, r2[4:0], rs1, f3, rd, OP_IMM};
            end else begin
                prog[i] = {r2[11:0], rs1, f3, rd, OP_IMM};
            end
        end
    endtask

    task automatic build_expected();
        xlen_t pc, wd, npc;
        logic we;
        reg_idx_t rd;
        int tail;
        foreach (model_regs[i]) model_regs[i] = '0;
        pc = RESET_PC;
        tail = 0;
        while (tail < NUM_TAIL && exp_pc.size() < MAX_RET) begin
            ref_step(pc, fetch_word(pc), we, rd, wd, npc);
            if (we) model_regs[rd] = wd;
            exp_pc.push_back(pc);
            exp_we.push_back(we);
            exp_rd.push_back(rd);
            exp_wdata.push_back(wd);
            exp_npc.push_back(npc);
            if (!in_prog(pc)) tail++;
            pc = npc;
        end
    endtask

    task automatic check_word(string name, xlen_t exp, xlen_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b actual %b", $time, name, exp, act);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin
        reset = 1'b1;
        imem_rdata = NOP;
        req_addr = '0;
        lat_cnt = 0;
        ret_count = 0;
        seen_req = 1'b0;
        exp_ready = 1'b0;
        seed = 32'h9088_3538;
        gen_program();
        build_expected();
        exp_ready = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

    // instruction memory, data valid IMEM_LATENCY cycles after the request
    always @(posedge clk) begin
        if (imem_req) begin
            lat_cnt <= IMEM_LATENCY - 1;
            req_addr <= imem_addr;
            imem_rdata <= 'x;
        end else if (lat_cnt != 0) begin
            lat_cnt <= lat_cnt - 1;
            if (lat_cnt == 1) imem_rdata <= fetch_word(req_addr);
        end
    end

    always @(negedge clk) begin
        if (!reset && imem_req && !seen_req) begin
            check_word("imem_addr", RESET_PC, imem_addr); // first fetch
            seen_req = 1'b1;
        end
        if (!reset && retire) begin
            check_word("retire_pc", exp_pc[ret_count], retire_pc);
            check_bit("retire_we", exp_we[ret_count], retire_we);
            if (exp_we[ret_count]) begin
                check_idx("retire_rd", exp_rd[ret_count], retire_rd);
                check_word("retire_wdata", exp_wdata[ret_count], retire_wdata);
            end
            check_word("retire_next_pc", exp_npc[ret_count], retire_next_pc);
            ret_count++;
            if (ret_count == exp_pc.size()) begin
                $display("TB PASSED");
                $finish;
            end
        end
    end

    initial begin
        wait (exp_ready);
        #(exp_pc.size() * (IMEM_LATENCY + 2) * 8 + 400);
        $display("timeout: the core stopped retiring after %0d instructions", ret_count);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: testbench/rv_core_checker.sv
/* timing assertions on the fetch and retire ports of the core
   attached to every rv_core instance by the bind below */
`timescale 1ns/1ps

module rv_core_checker (
    input logic          clk,
    input logic          reset,
    input logic          imem_req,
    input rv_pkg::xlen_t imem_addr,
    input logic          retire
);
    import rv_pkg::*;

    a_req_pulse: assert property (@(posedge clk) disable iff (reset)
        imem_req |=> !imem_req) else $error("imem_req longer than one cycle");

    a_retire_latency: assert property (@(posedge clk) disable iff (reset)
        imem_req |-> ##(IMEM_LATENCY + 1) retire) else $error("retire late or missing");

    a_req_period: assert property (@(posedge clk) disable iff (reset)
        imem_req |-> ##(IMEM_LATENCY + 2) imem_req) else $error("request spacing wrong");

    a_quiet_in_reset: assert property (@(posedge clk)
        reset |-> (!imem_req && !retire)) else $error("activity during reset");

    // pc only moves at the edge before a new request
    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        !imem_req |-> $stable(imem_addr)) else $error("imem_addr changed between requests");

endmodule

bind rv_core rv_core_checker u_checker (.clk(clk), .reset(reset), .imem_req(imem_req),
                                        .imem_addr(imem_addr), .retire(retire));

// File: testbench/tb_clock.sv
/* free-running testbench clock, 8 ns period */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 4; // ns

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: source/rv_core.sv
/* top level of the multi-cycle RV32I core
   fetches over a plain request port and reports each retired instruction */
`timescale 1ns/1ps

module rv_core (
    input  logic             clk,
    input  logic             reset,
    output logic             imem_req,
    output rv_pkg::xlen_t    imem_addr,
    input  rv_pkg::xlen_t    imem_rdata,
    output logic             retire,
    output rv_pkg::xlen_t    retire_pc,
    output rv_pkg::xlen_t    retire_next_pc,
    output logic             retire_we,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::xlen_t    retire_wdata
);
    import rv_pkg::*;

    logic       start, done, fetch, capture, execute;
    xlen_t      pc, next_pc, wdata, imm, rs1_data, rs2_data;
    inst_word_u ir; // instruction register
    reg_idx_t   rs1, rs2, rd;
    alu_op_e    alu_op;
    logic       src_a_pc, src_a_zero, src_b_imm;
    logic       is_branch, is_jal, is_jalr;
    logic       dec_we, rf_we;
    logic [2:0] funct3;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (execute) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            ir <= imem_rdata;
        end
    end

    assign rf_we = dec_we && execute; // write only in the retire cycle

    core_sequencer u_seq (.clk(clk), .reset(reset), .done(done), .start(start),
                          .fetch(fetch), .capture(capture), .execute(execute));

    fetch_wait_counter u_wait (.clk(clk), .reset(reset), .start(start), .done(done));

    inst_decoder u_dec (
        .inst(ir), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .src_a_pc(src_a_pc), .src_a_zero(src_a_zero), .src_b_imm(src_b_imm),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .funct3(funct3), .we(dec_we)
    );

    exec_unit u_exec (
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .alu_op(alu_op),
        .src_a_pc(src_a_pc), .src_a_zero(src_a_zero), .src_b_imm(src_b_imm),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .funct3(funct3), .wdata(wdata), .next_pc(next_pc)
    );

    reg_file u_rf (
        .clk(clk), .reset(reset), .we(rf_we), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
        .wdata(wdata), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    assign imem_req  = fetch;
    assign imem_addr = pc; // held until the next request

    assign retire         = execute;
    assign retire_pc      = pc;
    assign retire_next_pc = next_pc;
    assign retire_we      = dec_we;
    assign retire_rd      = rd;
    assign retire_wdata   = wdata;

endmodule

// File: source/reg_file.sv
/* 32 x 32 integer register file, two read ports and one write port
   x0 stays zero because the decoder never enables a write to it */
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    input  rv_pkg::xlen_t    wdata,
    output rv_pkg::xlen_t    rdata1,
    output rv_pkg::xlen_t    rdata2
);
    import rv_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata; // at the edge that ends EXEC
        end
    end

    // asynchronous reads
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// File: source/exec_unit.sv
/* combinational execute stage of the core
   ALU, branch compare, next PC and writeback value */
`timescale 1ns/1ps

module exec_unit (
    input  rv_pkg::xlen_t   pc,
    input  rv_pkg::xlen_t   rs1_data,
    input  rv_pkg::xlen_t   rs2_data,
    input  rv_pkg::xlen_t   imm,
    input  rv_pkg::alu_op_e alu_op,
    input  logic            src_a_pc,
    input  logic            src_a_zero,
    input  logic            src_b_imm,
    input  logic            is_branch,
    input  logic            is_jal,
    input  logic            is_jalr,
    input  logic [2:0]      funct3,
    output rv_pkg::xlen_t   wdata,
    output rv_pkg::xlen_t   next_pc
);
    import rv_pkg::*;

    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      alu_result;
    xlen_t      pc_plus4;
    xlen_t      target;
    logic [4:0] shamt;
    logic       taken;

    assign op_a  = src_a_zero ? '0 : (src_a_pc ? pc : rs1_data);
    assign op_b  = src_b_imm ? imm : rs2_data;
    assign shamt = op_b[4:0]; // low five bits only

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = xlen_t'($signed(op_a) >>> shamt);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    // branch condition straight from the register operands
    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);                   // beq
            3'b001:  taken = (rs1_data != rs2_data);                   // bne
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  taken = (rs1_data < rs2_data);                    // bltu
            3'b111:  taken = (rs1_data >= rs2_data);                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign target   = pc + imm; // branch and jal

    always_comb begin
        if (is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (is_jal || (is_branch && taken)) begin
            next_pc = target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // link address for both jumps
    assign wdata = (is_jal || is_jalr) ? pc_plus4 : alu_result;

endmodule

// File: source/inst_decoder.sv
/* combinational decode of one instruction word
   fields, immediate, ALU operation, operand selects and control class */
`timescale 1ns/1ps

module inst_decoder (
    input  rv_pkg::inst_word_u inst,
    output rv_pkg::reg_idx_t   rs1,
    output rv_pkg::reg_idx_t   rs2,
    output rv_pkg::reg_idx_t   rd,
    output rv_pkg::xlen_t      imm,
    output rv_pkg::alu_op_e    alu_op,
    output logic               src_a_pc,
    output logic               src_a_zero,
    output logic               src_b_imm,
    output logic               is_branch,
    output logic               is_jal,
    output logic               is_jalr,
    output logic [2:0]         funct3,
    output logic               we
);
    import rv_pkg::*;

    opcode_e opcode;
    xlen_t   imm_i;
    xlen_t   imm_b;
    xlen_t   imm_u;
    xlen_t   imm_j;
    logic    alt;       // funct7 bit 5, sub and sra
    logic    writes_rd; // class with a destination register

    assign opcode = inst.r_view.opcode;
    assign rs1    = inst.r_view.rs1;
    assign rs2    = inst.r_view.rs2;
    assign rd     = inst.r_view.rd;
    assign funct3 = inst.r_view.funct3;
    assign alt    = inst.r_view.funct7[5];

    assign imm_i = {{20{inst.i_view.imm12[11]}}, inst.i_view.imm12};
    assign imm_b = {{20{inst.r_view.funct7[6]}}, inst.r_view.rd[0],
                    inst.r_view.funct7[5:0], inst.r_view.rd[4:1], 1'b0};
    assign imm_u = {inst.r_view.funct7, inst.r_view.rs2, inst.r_view.rs1,
                    inst.r_view.funct3, 12'b0};
    assign imm_j = {{12{inst.r_view.funct7[6]}}, inst.r_view.rs1, inst.r_view.funct3,
                    inst.r_view.rs2[0], inst.r_view.funct7[5:0], inst.r_view.rs2[4:1], 1'b0};

    // add for everything that is not an ALU instruction
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OP || opcode == OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (opcode == OP && alt) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL; // srai keeps the bit in imm[10]
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        imm        = '0;
        src_a_pc   = 1'b0;
        src_a_zero = 1'b0;
        src_b_imm  = 1'b0;
        is_branch  = 1'b0;
        is_jal     = 1'b0;
        is_jalr    = 1'b0;
        writes_rd  = 1'b0;
        case (opcode)
            OP: writes_rd = 1'b1;
            OP_IMM: begin
                imm       = imm_i;
                src_b_imm = 1'b1;
                writes_rd = 1'b1;
            end
            LUI: begin
                imm        = imm_u;
                src_a_zero = 1'b1; // 0 + imm
                src_b_imm  = 1'b1;
                writes_rd  = 1'b1;
            end
            AUIPC: begin
                imm       = imm_u;
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                writes_rd = 1'b1;
            end
            JAL: begin
                imm       = imm_j;
                is_jal    = 1'b1;
                writes_rd = 1'b1;
            end
            JALR: begin
                imm       = imm_i;
                src_b_imm = 1'b1; // target from the ALU
                is_jalr   = 1'b1;
                writes_rd = 1'b1;
            end
            BRANCH: begin
                imm       = imm_b;
                is_branch = 1'b1;
            end
            default: ; // unknown opcode retires as a no-op
        endcase
    end

    assign we = writes_rd && (rd != '0); // x0 never written

endmodule

// File: source/fetch_wait_counter.sv
/* times the fixed instruction memory latency after each request
   done marks the cycle in which imem_rdata is valid */
`timescale 1ns/1ps

module fetch_wait_counter (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic done
);
    import rv_pkg::*;

    logic [WAIT_CNT_W-1:0] count; // cycles left until rdata

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= WAIT_CNT_W'(IMEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last wait cycle, count reaches zero on the next edge
    assign done = (count == WAIT_CNT_W'(1));

endmodule

// File: source/core_sequencer.sv
/* fetch / wait / execute sequencing of the core
   one instruction in flight, no back-pressure */
`timescale 1ns/1ps

module core_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic done,
    output logic start,
    output logic fetch,
    output logic capture,
    output logic execute
);
    import rv_pkg::*;

    seq_state_e state;
    seq_state_e next_state;
    logic       armed; // low until the first edge after reset

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            armed <= 1'b0;
        end else begin
            state <= next_state;
            armed <= 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            FETCH: begin
                if (armed) begin
                    next_state = WAIT;
                end
            end
            WAIT: begin
                if (done) begin
                    next_state = EXEC;
                end
            end
            EXEC:    next_state = FETCH; // retire, then fetch the next one
            default: next_state = FETCH;
        endcase
    end

    // request goes out once the sequencer is armed
    assign fetch   = (state == FETCH) && armed;
    assign start   = fetch;                   // counter starts with the request
    assign capture = (state == WAIT) && done; // rdata valid in this cycle
    assign execute = (state == EXEC);

endmodule

// File: source/rv_pkg.sv
/* shared types and constants of the multi-cycle RV32I core
   imported by every RTL unit and by the testbench */
package rv_pkg;

    typedef logic [31:0] xlen_t;    // data and address word
    typedef logic [4:0]  reg_idx_t; // register index

    localparam xlen_t RESET_PC     = 32'h8000_0000; // first fetch address
    localparam int    IMEM_LATENCY = 2;             // cycles from imem_req to valid rdata

    // width of the fetch wait counter
    localparam int    WAIT_CNT_W   = $clog2(IMEM_LATENCY + 1);

    // opcode field, only the classes the core executes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // register layout, also the source of the B, U and J immediate bits
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12; // sign bit on top
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } inst_word_u;

    typedef enum logic [1:0] {
        FETCH,
        WAIT,
        EXEC
    } seq_state_e;

endpackage
